//--- pkt_sched.f
source/sched_pkg.sv
source/rr_arbiter.sv
source/desc_fifo.sv
source/max_slot_select.sv
source/core_reset_seq.sv
source/desc_assign.sv
source/pkt_sched.sv
verif/sched_model.sv
verif/pkt_sched_tb.sv

//--- verif/pkt_sched_tb.sv
`timescale 1ns/1ps

module pkt_sched_tb
  import sched_pkg::*;
();

  localparam int PKTS      = 40;
  localparam int MSG_COUNT = 150;
  localparam int MAX_WORDS = IF_COUNT * PKTS * 6;
  localparam int LIMIT     = 40 * (MAX_WORDS + MSG_COUNT + IF_COUNT * PKTS) + 2000;

  logic clk;
  logic rst;
  logic [IF_COUNT-1:0][DATA_WIDTH-1:0] rx_tdata;
  logic [IF_COUNT-1:0] rx_tvalid, rx_tready, rx_tlast;
  logic [IF_COUNT-1:0][DATA_WIDTH-1:0] pkt_tdata;
  desc_t [IF_COUNT-1:0] pkt_tdest;
  if_id_t [IF_COUNT-1:0] pkt_tuser;
  logic [IF_COUNT-1:0] pkt_tvalid, pkt_tready, pkt_tlast;
  logic [IF_COUNT-1:0][DATA_WIDTH-1:0] core_tdata, tx_tdata;
  logic [IF_COUNT-1:0] core_tvalid, core_tready, core_tlast;
  logic [IF_COUNT-1:0] tx_tvalid, tx_tready, tx_tlast;
  logic [CTRL_WIDTH-1:0] cin_tdata, cout_tdata;
  core_id_t cin_tuser, cout_tdest;
  logic cin_tvalid, cin_tready, cout_tvalid, cout_tready, cout_tlast;

  pkt_sched dut (.*);
  sched_model model ();

  // per lane stimulus and tracking
  logic [DATA_WIDTH-1:0] exp_word [IF_COUNT];
  int    words_left [IF_COUNT];
  int    pkts_started [IF_COUNT];
  int    pkts_done [IF_COUNT];
  bit    taken [IF_COUNT];
  bit    in_pkt [IF_COUNT];
  bit    pend_v [IF_COUNT];
  desc_t pend [IF_COUNT];
  desc_t cur [IF_COUNT];

  // kind of control message in flight (0 free, 1 loopback, 2 dropped)
  int       cin_kind;
  core_id_t cin_core;
  slot_t    cin_slot;
  bit       cin_taken;
  int       msgs_sent;
  int       rst_seen;
  int       err_count;
  bit       done;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fail_run(string why);
    $display("%0t: %s", $time, why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_data(string name, logic [DATA_WIDTH-1:0] got, logic [DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("MISMATCH %0t %s got %h expected %h", $time, name, got, exp);
      fail_run("packet word differs");
    end
  endtask

  task automatic check_desc(string name, desc_t got, desc_t exp);
    if (got !== exp) begin
      err_count++;
      $display("MISMATCH %0t %s got core %0d slot %0d expected core %0d slot %0d",
               $time, name, got.core, got.slot, exp.core, exp.slot);
      fail_run("descriptor differs");
    end
  endtask

  task automatic check_ctrl(string name, logic [CTRL_WIDTH-1:0] got, logic [CTRL_WIDTH-1:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("MISMATCH %0t %s got %h expected %h", $time, name, got, exp);
      fail_run("control word differs");
    end
  endtask

  task automatic check_core(string name, core_id_t got, core_id_t exp);
    if (got !== exp) begin
      err_count++;
      $display("MISMATCH %0t %s got %0d expected %0d", $time, name, got, exp);
      fail_run("core number differs");
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      err_count++;
      $display("MISMATCH %0t %s got %b expected %b", $time, name, got, exp);
      fail_run("control bit differs");
    end
  endtask

  // pick and drive the next control message
  task automatic next_ctrl();
    logic [CTRL_WIDTH-1:0] d;
    core_id_t c;
    slot_t s;
    int r;
    bit more;
    more = (msgs_sent < MSG_COUNT) || (pkts_done[0] + pkts_done[1] < IF_COUNT * PKTS);
    if (!more || $urandom % 100 >= 50) begin
      cin_tvalid <= 1'b0;
      return;
    end
    d = {$urandom, $urandom};
    r = $urandom % 100;
    cin_core = core_id_t'($urandom % CORE_COUNT);
    if (r < 60 || msgs_sent >= MSG_COUNT) begin
      if (model.pick_idle(c, s)) begin
        cin_kind = 0;
        cin_core = c;
        cin_slot = s;
        d[CTRL_WIDTH-1 -: 4] = MSG_SLOT_FREE;
        d[LEN_WIDTH +: SLOT_WIDTH] = s;
      end else if (msgs_sent >= MSG_COUNT) begin
        cin_tvalid <= 1'b0;
        return;
      end else begin
        cin_kind = 1;
        d[CTRL_WIDTH-1 -: 4] = MSG_LOOPBACK;
      end
    end else if (r < 75) begin
      cin_kind = 1;
      d[CTRL_WIDTH-1 -: 4] = MSG_LOOPBACK;
    end else if (r < 88) begin
      // free message with slot 0
      cin_kind = 2;
      d[CTRL_WIDTH-1 -: 4] = MSG_SLOT_FREE;
      d[LEN_WIDTH +: SLOT_WIDTH] = '0;
    end else begin
      cin_kind = 2;
      d[CTRL_WIDTH-1 -: 4] = 4'(2 + $urandom % 14);
    end
    msgs_sent++;
    cin_tdata  <= d;
    cin_tuser  <= cin_core;
    cin_tvalid <= 1'b1;
  endtask

  task automatic monitor();
    desc_t d;
    loop_t e;
    int l;
    bit held;
    for (int i = 0; i < IF_COUNT; i++) begin
      check_data("tx_tdata", tx_tdata[i], core_tdata[i]);
      check_flag("tx_tvalid", tx_tvalid[i], core_tvalid[i]);
      check_flag("tx_tlast", tx_tlast[i], core_tlast[i]);
      check_flag("core_tready", core_tready[i], tx_tready[i]);
      taken[i] = 1'b0;
      // a lane moves words only while it holds a descriptor
      held = pend_v[i] || in_pkt[i];
      check_flag("rx_tready", rx_tready[i], pkt_tready[i] && held);
      check_flag("pkt_tvalid", pkt_tvalid[i], rx_tvalid[i] && held);
      if (pkt_tvalid[i] && pkt_tready[i]) begin
        taken[i] = 1'b1;
        check_data("pkt_tdata", pkt_tdata[i], exp_word[i]);
        check_flag("pkt_tlast", pkt_tlast[i], rx_tlast[i]);
        check_flag("pkt_tuser", pkt_tuser[i], if_id_t'(i));
        if (!in_pkt[i]) begin
          cur[i] = pend[i];
          pend_v[i] = 1'b0;
        end
        check_desc("pkt_tdest", pkt_tdest[i], cur[i]);
        in_pkt[i] = !pkt_tlast[i];
        if (pkt_tlast[i]) begin
          model.release_slot(cur[i]);
          pkts_done[i]++;
        end
      end
    end
    // descriptor handed to a lane this cycle
    if (|dut.lane_assign.grant) begin
      l = dut.lane_assign.grant[1] ? 1 : 0;
      if (pend_v[l]) fail_run("second descriptor granted to a lane");
      if (!model.take_desc(d)) fail_run("descriptor granted while no free slot is held");
      pend[l] = d;
      pend_v[l] = 1'b1;
    end
    // loopback messages wait while the loopback queue is full
    if (cin_tvalid) begin
      check_flag("cin_tready", cin_tready,
                 (cin_kind != 1) || (model.loop_count() < LOOP_DEPTH));
    end
    cin_taken = cin_tvalid && cin_tready;
    if (cin_taken) begin
      if (cin_kind == 0) model.push_free(cin_core, cin_slot);
      if (cin_kind == 1) model.push_loop({cin_core, 4'h0, cin_tdata[CTRL_WIDTH-5:0]});
    end
    if (cout_tvalid && cout_tready) begin
      check_flag("cout_tlast", cout_tlast, 1'b1);
      if (rst_seen < CORE_COUNT) begin
        check_ctrl("cout_tdata", cout_tdata, RST_MSG);
        check_core("cout_tdest", cout_tdest, core_id_t'(rst_seen));
        rst_seen++;
      end else begin
        if (!model.pop_loop(e)) fail_run("control output sent a word nobody queued");
        check_ctrl("cout_tdata", cout_tdata, e.ctrl);
        check_core("cout_tdest", cout_tdest, e.core);
      end
    end
  endtask

  task automatic drive();
    for (int i = 0; i < IF_COUNT; i++) begin
      if (!rx_tvalid[i] || taken[i]) begin
        if (words_left[i] == 0 && pkts_started[i] < PKTS) begin
          words_left[i] = 1 + $urandom % 6;
          pkts_started[i]++;
        end
        if (words_left[i] > 0 && $urandom % 100 < 70) begin
          exp_word[i] = {$urandom, $urandom};
          rx_tdata[i]  <= exp_word[i];
          rx_tlast[i]  <= (words_left[i] == 1);
          rx_tvalid[i] <= 1'b1;
          words_left[i]--;
        end else begin
          rx_tvalid[i] <= 1'b0;
        end
      end
      pkt_tready[i]  <= ($urandom % 100 < 75);
      core_tdata[i]  <= {$urandom, $urandom};
      core_tvalid[i] <= $urandom % 2;
      core_tlast[i]  <= $urandom % 2;
      tx_tready[i]   <= $urandom % 2;
    end
    if (!cin_tvalid || cin_taken) next_ctrl();
    cout_tready <= ($urandom % 100 < 70);
  endtask

  initial begin
    void'($urandom(89012));
    rst = 1'b1;
    rx_tdata = '0;
    rx_tvalid = '0;
    rx_tlast = '0;
    pkt_tready = '0;
    core_tdata = '0;
    core_tvalid = '0;
    core_tlast = '0;
    tx_tready = '0;
    cin_tdata = '0;
    cin_tuser = '0;
    cin_tvalid = 1'b0;
    cout_tready = 1'b0;
    for (int i = 0; i < IF_COUNT; i++) begin
      words_left[i] = 0;
      pkts_started[i] = 0;
      pkts_done[i] = 0;
      in_pkt[i] = 1'b0;
      pend_v[i] = 1'b0;
      taken[i] = 1'b0;
    end
    msgs_sent = 0;
    rst_seen = 0;
    err_count = 0;
    cin_taken = 1'b0;
    done = 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    while (!done) begin
      @(posedge clk);
      monitor();
      drive();
      done = (pkts_done[0] + pkts_done[1] == IF_COUNT * PKTS) && msgs_sent >= MSG_COUNT
          && !cin_tvalid && rst_seen == CORE_COUNT && model.loop_count() == 0;
    end
    if (err_count == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1);
    end
  end

  // watchdog
  initial begin
    repeat (LIMIT + 8) @(posedge clk);
    fail_run("timeout waiting for traffic to drain");
  end

endmodule

//--- verif/sched_model.sv
`timescale 1ns/1ps

module sched_model
  import sched_pkg::*;
();

  // free slots queued per core, in arrival order
  slot_t       fq    [CORE_COUNT][SLOT_COUNT];
  int unsigned fhead [CORE_COUNT];
  int unsigned fcnt  [CORE_COUNT];
  // slots held by the core, eligible for a free message
  bit          idle  [CORE_COUNT][SLOT_COUNT+1];
  loop_t       loop_exp[$];

  initial begin
    for (int c = 0; c < CORE_COUNT; c++) begin
      fhead[c] = 0;
      fcnt[c]  = 0;
      idle[c][0] = 1'b0;
      for (int s = 1; s <= SLOT_COUNT; s++) begin
        idle[c][s] = 1'b1;
      end
    end
  end

  // random core with an idle slot, lowest idle slot of that core
  function automatic bit pick_idle(output core_id_t c, output slot_t s);
    int start;
    int k;
    start = $urandom % CORE_COUNT;
    for (int i = 0; i < CORE_COUNT; i++) begin
      k = (start + i) % CORE_COUNT;
      for (int j = 1; j <= SLOT_COUNT; j++) begin
        if (idle[k][j]) begin
          idle[k][j] = 1'b0;
          c = core_id_t'(k);
          s = slot_t'(j);
          return 1'b1;
        end
      end
    end
    return 1'b0;
  endfunction

  function automatic void push_free(core_id_t c, slot_t s);
    fq[c][(fhead[c] + fcnt[c]) % SLOT_COUNT] = s;
    fcnt[c]++;
  endfunction

  // largest queue wins, a tie goes to the lower core
  function automatic bit take_desc(output desc_t d);
    int best;
    best = 0;
    for (int c = 1; c < CORE_COUNT; c++) begin
      if (fcnt[c] > fcnt[best]) best = c;
    end
    if (fcnt[best] == 0) return 1'b0;
    d.core = core_id_t'(best);
    d.slot = fq[best][fhead[best]];
    fhead[best] = (fhead[best] + 1) % SLOT_COUNT;
    fcnt[best]--;
    return 1'b1;
  endfunction

  function automatic void release_slot(desc_t d);
    idle[d.core][d.slot] = 1'b1;
  endfunction

  function automatic void push_loop(loop_t e);
    loop_exp.push_back(e);
  endfunction

  function automatic bit pop_loop(output loop_t e);
    if (loop_exp.size() == 0) return 1'b0;
    e = loop_exp.pop_front();
    return 1'b1;
  endfunction

  function automatic int loop_count();
    return loop_exp.size();
  endfunction

endmodule

//--- source/pkt_sched.sv
`timescale 1ns/1ps

module pkt_sched
  import sched_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst,
  // from Ethernet
  input  logic [IF_COUNT-1:0][DATA_WIDTH-1:0] rx_tdata,
  input  logic [IF_COUNT-1:0]                 rx_tvalid,
  output logic [IF_COUNT-1:0]                 rx_tready,
  input  logic [IF_COUNT-1:0]                 rx_tlast,
  // to cores
  output logic [IF_COUNT-1:0][DATA_WIDTH-1:0] pkt_tdata,
  output desc_t [IF_COUNT-1:0]                pkt_tdest,
  output if_id_t [IF_COUNT-1:0]               pkt_tuser,
  output logic [IF_COUNT-1:0]                 pkt_tvalid,
  input  logic [IF_COUNT-1:0]                 pkt_tready,
  output logic [IF_COUNT-1:0]                 pkt_tlast,
  // return path
  input  logic [IF_COUNT-1:0][DATA_WIDTH-1:0] core_tdata,
  input  logic [IF_COUNT-1:0]                 core_tvalid,
  output logic [IF_COUNT-1:0]                 core_tready,
  input  logic [IF_COUNT-1:0]                 core_tlast,
  output logic [IF_COUNT-1:0][DATA_WIDTH-1:0] tx_tdata,
  output logic [IF_COUNT-1:0]                 tx_tvalid,
  input  logic [IF_COUNT-1:0]                 tx_tready,
  output logic [IF_COUNT-1:0]                 tx_tlast,
  // control from cores
  input  logic [CTRL_WIDTH-1:0]               cin_tdata,
  input  core_id_t                            cin_tuser,
  input  logic                                cin_tvalid,
  output logic                                cin_tready,
  // control to cores
  output logic [CTRL_WIDTH-1:0]               cout_tdata,
  output core_id_t                            cout_tdest,
  output logic                                cout_tvalid,
  input  logic                                cout_tready,
  output logic                                cout_tlast
);

  msg_type_t msg_type;
  slot_t     msg_slot;
  logic      is_free;
  logic      is_loop;
  logic      slot_ok;

  slot_t [CORE_COUNT-1:0] slot_head;
  slot_t [CORE_COUNT-1:0] slot_count;
  logic  [CORE_COUNT-1:0] slot_valid;
  logic  [CORE_COUNT-1:0] slot_push;
  logic  [CORE_COUNT-1:0] slot_in_ready;
  logic  [CORE_COUNT-1:0] slot_pop;

  core_id_t best_core;
  logic     desc_valid;
  desc_t    desc_data;
  logic     desc_pop;

  logic  loop_push;
  logic  loop_in_ready;
  logic  loop_valid;
  loop_t loop_data;
  logic  loop_ready;

  // control word decode
  assign msg_type = msg_type_t'(cin_tdata[CTRL_WIDTH-1 -: 4]);
  assign msg_slot = cin_tdata[LEN_WIDTH +: SLOT_WIDTH];
  assign is_free  = (msg_type == MSG_SLOT_FREE);
  assign is_loop  = (msg_type == MSG_LOOPBACK);
  assign slot_ok  = (msg_slot != '0) && (msg_slot <= SLOT_WIDTH'(SLOT_COUNT));

  assign loop_push = cin_tvalid && is_loop;

  // slot 0 and unknown types are taken and dropped
  assign cin_tready = is_free ? (!slot_ok || slot_in_ready[cin_tuser]) :
                      is_loop ? loop_in_ready : 1'b1;

  for (genvar i = 0; i < CORE_COUNT; i++) begin : g_core
    assign slot_push[i] = cin_tvalid && is_free && slot_ok && (cin_tuser == core_id_t'(i));
    assign slot_pop[i]  = desc_pop && (best_core == core_id_t'(i));

    desc_fifo #(
      .payload_t(slot_t),
      .DEPTH(SLOT_COUNT)
    ) slot_fifo (
      .clk(clk),
      .rst(rst),
      .clear(1'b0),
      .in_valid(slot_push[i]),
      .in_data(msg_slot),
      .in_ready(slot_in_ready[i]),
      .out_valid(slot_valid[i]),
      .out_data(slot_head[i]),
      .out_ready(slot_pop[i]),
      .count(slot_count[i])
    );
  end

  max_slot_select core_pick (
    .counts(slot_count),
    .best(best_core)
  );

  // the fullest core is non-empty whenever any core is
  assign desc_valid     = slot_valid[best_core];
  assign desc_data.core = best_core;
  assign desc_data.slot = slot_head[best_core];

  desc_assign lane_assign (
    .clk(clk),
    .rst(rst),
    .rx_tdata(rx_tdata),
    .rx_tvalid(rx_tvalid),
    .rx_tready(rx_tready),
    .rx_tlast(rx_tlast),
    .pkt_tdata(pkt_tdata),
    .pkt_tdest(pkt_tdest),
    .pkt_tuser(pkt_tuser),
    .pkt_tvalid(pkt_tvalid),
    .pkt_tready(pkt_tready),
    .pkt_tlast(pkt_tlast),
    .desc_valid(desc_valid),
    .desc_data(desc_data),
    .desc_pop(desc_pop)
  );

  desc_fifo #(
    .payload_t(loop_t),
    .DEPTH(LOOP_DEPTH)
  ) loop_fifo (
    .clk(clk),
    .rst(rst),
    .clear(1'b0),
    .in_valid(loop_push),
    .in_data({cin_tuser, cin_tdata}),
    .in_ready(loop_in_ready),
    .out_valid(loop_valid),
    .out_data(loop_data),
    .out_ready(loop_ready),
    .count()
  );

  core_reset_seq ctrl_out (
    .clk(clk),
    .rst(rst),
    .loop_valid(loop_valid),
    .loop_data(loop_data),
    .loop_ready(loop_ready),
    .cout_tdata(cout_tdata),
    .cout_tdest(cout_tdest),
    .cout_tvalid(cout_tvalid),
    .cout_tready(cout_tready),
    .cout_tlast(cout_tlast)
  );

  // cores to Ethernet, straight through
  assign tx_tdata    = core_tdata;
  assign tx_tvalid   = core_tvalid;
  assign tx_tlast    = core_tlast;
  assign core_tready = tx_tready;

endmodule

//--- source/desc_assign.sv
`timescale 1ns/1ps

module desc_assign
  import sched_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst,
  input  logic [IF_COUNT-1:0][DATA_WIDTH-1:0] rx_tdata,
  input  logic [IF_COUNT-1:0]                 rx_tvalid,
  output logic [IF_COUNT-1:0]                 rx_tready,
  input  logic [IF_COUNT-1:0]                 rx_tlast,
  output logic [IF_COUNT-1:0][DATA_WIDTH-1:0] pkt_tdata,
  output desc_t [IF_COUNT-1:0]                pkt_tdest,
  output if_id_t [IF_COUNT-1:0]               pkt_tuser,
  output logic [IF_COUNT-1:0]                 pkt_tvalid,
  input  logic [IF_COUNT-1:0]                 pkt_tready,
  output logic [IF_COUNT-1:0]                 pkt_tlast,
  input  logic                                desc_valid,
  input  desc_t                               desc_data,
  output logic                                desc_pop
);

  // destination held per lane
  desc_t [IF_COUNT-1:0] dest_r;
  logic  [IF_COUNT-1:0] dest_v;
  logic  [IF_COUNT-1:0] last_xfer;
  logic  [IF_COUNT-1:0] desc_req;
  logic  [IF_COUNT-1:0] grant;
  logic                 grant_valid;

  assign last_xfer = rx_tvalid & rx_tready & rx_tlast;

  // empty lanes, or lanes finishing a packet, ask for the next descriptor
  assign desc_req = (~dest_v | last_xfer) & {IF_COUNT{desc_valid}};

  rr_arbiter #(
    .PORTS(IF_COUNT)
  ) lane_arb (
    .clk(clk),
    .rst(rst),
    .request(desc_req),
    .grant(grant),
    .grant_valid(grant_valid),
    .grant_enc()
  );

  assign desc_pop = grant_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      dest_v <= '0;
    end else begin
      // a fresh grant wins over the last-word clear
      dest_v <= (dest_v & ~last_xfer) | grant;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < IF_COUNT; i++) begin
      if (grant[i]) begin
        dest_r[i] <= desc_data;
      end
    end
  end

  assign pkt_tdata  = rx_tdata;
  assign pkt_tlast  = rx_tlast;
  assign pkt_tdest  = dest_r;
  assign pkt_tvalid = rx_tvalid & dest_v;
  assign rx_tready  = pkt_tready & dest_v;

  for (genvar i = 0; i < IF_COUNT; i++) begin : g_lane
    assign pkt_tuser[i] = if_id_t'(i);

    // destination stays put for the whole packet
    a_dest_hold: assert property (@(posedge clk) disable iff (rst)
      pkt_tvalid[i] && !(pkt_tready[i] && pkt_tlast[i]) |=>
        (pkt_tdest[i] == $past(pkt_tdest[i])));
  end

endmodule

//--- source/core_reset_seq.sv
`timescale 1ns/1ps

module core_reset_seq
  import sched_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  loop_valid,
  input  loop_t                 loop_data,
  output logic                  loop_ready,
  output logic [CTRL_WIDTH-1:0] cout_tdata,
  output core_id_t              cout_tdest,
  output logic                  cout_tvalid,
  input  logic                  cout_tready,
  output logic                  cout_tlast
);

  // one extra bit so the count can reach CORE_COUNT and park there
  logic [CORE_ID_WIDTH:0] rst_cnt;
  logic                   rst_busy;

  assign rst_busy = (rst_cnt < (CORE_ID_WIDTH + 1)'(CORE_COUNT));

  always_ff @(posedge clk) begin
    if (rst) begin
      rst_cnt <= '0;
    end else if (rst_busy && cout_tready) begin
      rst_cnt <= rst_cnt + 1'b1;
    end
  end

  // loopback words leave with a zero type nibble
  assign cout_tdata  = rst_busy ? RST_MSG
                                : {4'h0, loop_data.ctrl[CTRL_WIDTH-5:0]};
  assign cout_tdest  = rst_busy ? rst_cnt[CORE_ID_WIDTH-1:0] : loop_data.core;
  assign cout_tvalid = rst_busy || loop_valid;
  assign cout_tlast  = cout_tvalid;

  // fifo drains only after the reset walk
  assign loop_ready = !rst_busy && cout_tready;

  // a stalled word keeps its value, whichever source it came from
  a_cout_hold: assert property (@(posedge clk) disable iff (rst)
    cout_tvalid && !cout_tready |=>
      cout_tvalid && $stable(cout_tdata) && $stable(cout_tdest));

endmodule

//--- source/max_slot_select.sv
`timescale 1ns/1ps

module max_slot_select
  import sched_pkg::*;
(
  input  slot_t [CORE_COUNT-1:0] counts,
  output core_id_t               best
);

  always_comb begin
    slot_t    val [CORE_COUNT];
    core_id_t idx [CORE_COUNT];
    int       width;
    for (int i = 0; i < CORE_COUNT; i++) begin
      val[i] = counts[i];
      idx[i] = core_id_t'(i);
    end
    width = CORE_COUNT;
    // each level halves the candidates in place
    for (int lvl = 0; lvl < CORE_ID_WIDTH + 1; lvl++) begin
      if (width > 1) begin
        for (int j = 0; j < CORE_COUNT / 2; j++) begin
          if (j < width / 2) begin
            // strict compare keeps the lower index on a tie
            if (val[2*j+1] > val[2*j]) begin
              val[j] = val[2*j+1];
              idx[j] = idx[2*j+1];
            end else begin
              val[j] = val[2*j];
              idx[j] = idx[2*j];
            end
          end
        end
        // odd one out moves up unchanged
        if (width % 2 == 1) begin
          val[width/2] = val[width-1];
          idx[width/2] = idx[width-1];
        end
        width = (width + 1) / 2;
      end
    end
    best = idx[0];
  end

endmodule

//--- source/desc_fifo.sv
`timescale 1ns/1ps

module desc_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int DEPTH = 4,
  parameter int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  parameter int CW = $clog2(DEPTH + 1)
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          clear,
  input  logic          in_valid,
  input  payload_t      in_data,
  output logic          in_ready,
  output logic          out_valid,
  output payload_t      out_data,
  input  logic          out_ready,
  output logic [CW-1:0] count
);

  payload_t mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          full;
  logic          empty;
  logic          push;
  logic          pop;

  assign full  = (count == CW'(DEPTH));
  assign empty = (count == '0);

  assign in_ready  = !full;
  assign out_valid = !empty;
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // occupancy follows the two handshakes
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // a full buffer only drains through a pop
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    full && !pop && !clear |=> full && (wr_ptr == $past(wr_ptr)));

  // an empty buffer only fills through a push
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    empty && !push |=> empty && (rd_ptr == $past(rd_ptr)));

endmodule

//--- source/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter #(
  parameter int PORTS = 2,
  parameter int ENC_WIDTH = (PORTS > 1) ? $clog2(PORTS) : 1
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [PORTS-1:0]     request,
  output logic [PORTS-1:0]     grant,
  output logic                 grant_valid,
  output logic [ENC_WIDTH-1:0] grant_enc
);

  // first requester to look at this cycle
  logic [ENC_WIDTH-1:0] ptr;

  always_comb begin
    int unsigned idx;
    grant       = '0;
    grant_valid = 1'b0;
    grant_enc   = '0;
    // scan from the pointer, wrapping around
    for (int i = 0; i < PORTS; i++) begin
      idx = (int'(ptr) + i) % PORTS;
      if (!grant_valid && request[idx]) begin
        grant[idx]  = 1'b1;
        grant_valid = 1'b1;
        grant_enc   = ENC_WIDTH'(idx);
      end
    end
  end

  // winner goes to the back of the line
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (grant_valid) begin
      ptr <= (grant_enc == ENC_WIDTH'(PORTS - 1)) ? '0 : grant_enc + 1'b1;
    end
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
    (|request) |-> (grant_valid && $onehot(grant) && |(grant & request)));

endmodule

//--- source/sched_pkg.sv
package sched_pkg;

  // system sizes
  localparam int IF_COUNT   = 2;
  localparam int CORE_COUNT = 4;
  localparam int SLOT_COUNT = 4;
  localparam int DATA_WIDTH = 64;
  localparam int CTRL_WIDTH = 64;

  // slot field starts here in a control word
  localparam int LEN_WIDTH = 16;

  // slot numbers run 1..SLOT_COUNT, 0 means none
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1);
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT);
  localparam int IF_ID_WIDTH   = $clog2(IF_COUNT);

  localparam int LOOP_DEPTH = 16;

  typedef logic [SLOT_WIDTH-1:0]    slot_t;
  typedef logic [CORE_ID_WIDTH-1:0] core_id_t;
  typedef logic [IF_ID_WIDTH-1:0]   if_id_t;

  typedef struct packed {
    core_id_t core;
    slot_t    slot;
  } desc_t;

  typedef struct packed {
    core_id_t              core;
    logic [CTRL_WIDTH-1:0] ctrl;
  } loop_t;

  // top nibble of a control word
  typedef enum logic [3:0] {
    MSG_SLOT_FREE = 4'd0,
    MSG_LOOPBACK  = 4'd1
  } msg_type_t;

  localparam logic [CTRL_WIDTH-1:0] RST_MSG = {{(CTRL_WIDTH-1){1'b1}}, 1'b0};

endpackage
